// ==== rtl/bit_packer.sv ====
// bit packer
// appends variable-length codes MSB first into an accumulator and
// emits whole bytes. after the last code of a frame the remaining
// bits are padded with ones and an eof token closes the frame

`default_nettype none

module bit_packer (
    input  wire logic                  clock,
    input  wire logic                  nreset,
    input  wire jpeg_out_pkg::code_t   dec_i,
    input  wire logic                  dec_valid_i,
    output logic                       dec_ready_o,
    output jpeg_out_pkg::byte_tok_t    tok_o,
    output logic                       tok_valid_o,
    input  wire logic                  tok_ready_i
);
    import jpeg_out_pkg::*;

    // held bits sit at the top of the accumulator, zeros below them
    logic [ACC_W-1:0] acc_q;
    logic [LEN_W-1:0] fill_q;
    logic             finishing_q;

    logic             has_byte;
    logic             dec_take;
    logic             tok_take;
    logic [LEN_W-1:0] shift_amt;
    logic [ACC_W-1:0] appended;

    assign has_byte = (fill_q >= LEN_W'(8));

    // accept only with a partial byte held and no frame closing
    assign dec_ready_o = !has_byte && !finishing_q;
    assign tok_valid_o = has_byte || finishing_q;

    assign dec_take = dec_valid_i && dec_ready_o;
    assign tok_take = tok_valid_o && tok_ready_i;

    // new bits land just below the held bits
    // fill < 8 and len <= 32, so the shift is at least one
    assign shift_amt = LEN_W'(ACC_W) - fill_q - dec_i.len;
    assign appended  = ACC_W'(dec_i.bits) << shift_amt;

    //////////////////////////////////////////////////////////////////////
    // output token

    always_comb begin
        tok_o.data = acc_q[ACC_W-1 -: 8];
        tok_o.eof  = 1'b0;
        if (finishing_q && !has_byte) begin
            tok_o.eof = 1'b1;
            if (fill_q == '0) begin
                // frame ended on a byte boundary, nothing to send
                tok_o.data = 8'h00;
            end else begin
                // pad the low positions with ones
                tok_o.data = acc_q[ACC_W-1 -: 8] | (8'hFF >> fill_q);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accumulator

    always_ff @(posedge clock) begin
        if (nreset) begin
            acc_q       <= '0;
            fill_q      <= '0;
            finishing_q <= 1'b0;
        end else if (dec_take) begin
            acc_q  <= acc_q | appended;
            fill_q <= fill_q + dec_i.len;
            if (dec_i.last) begin
                finishing_q <= 1'b1;
            end
        end else if (tok_take) begin
            if (tok_o.eof) begin
                acc_q       <= '0;
                fill_q      <= '0;
                finishing_q <= 1'b0;
            end else begin
                acc_q  <= acc_q << 8;
                fill_q <= fill_q - LEN_W'(8);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/byte_stuffer.sv ====
// byte stuffer
// output stage of the JPEG stream. inserts 0x00 after every 0xFF data
// byte and closes each frame with the unstuffed marker 0xFF 0xD9

`default_nettype none

module byte_stuffer (
    input  wire logic                    clock,
    input  wire logic                    nreset,
    input  wire jpeg_out_pkg::byte_tok_t tok_i,
    input  wire logic                    tok_valid_i,
    output logic                         tok_ready_o,
    output jpeg_out_pkg::out_byte_t      out_o,
    output logic                         out_valid_o,
    input  wire logic                    out_ready_i
);
    import jpeg_out_pkg::*;

    // state names the byte to load once the output register frees up
    typedef enum logic [1:0] {
        ST_PASS,
        ST_STUFF,
        ST_MARKER_PREFIX,
        ST_MARKER_CODE
    } state_t;

    state_t    state_q;
    state_t    state_d;
    logic      eoi_pending_q;
    logic      eoi_pending_d;
    out_byte_t out_q;
    logic      out_valid_q;
    logic      slot_free;
    logic      tok_take;
    logic      tok_has_data;
    logic      load;
    out_byte_t load_byte;

    assign slot_free   = !out_valid_q || out_ready_i;
    assign tok_ready_o = (state_q == ST_PASS) && slot_free;
    assign tok_take    = tok_valid_i && tok_ready_o;

    // a padded final byte always ends in a one bit
    assign tok_has_data = !tok_i.eof || tok_i.data[0];

    //////////////////////////////////////////////////////////////////////
    // sequencer

    always_comb begin
        load          = 1'b0;
        load_byte     = '0;
        state_d       = state_q;
        eoi_pending_d = eoi_pending_q;
        case (state_q)
            ST_PASS: begin
                if (tok_take) begin
                    load = 1'b1;
                    if (tok_has_data) begin
                        load_byte.data = tok_i.data;
                        if (tok_i.data == MARKER_PREFIX) begin
                            state_d       = ST_STUFF;
                            eoi_pending_d = tok_i.eof;
                        end else if (tok_i.eof) begin
                            state_d = ST_MARKER_PREFIX;
                        end
                    end else begin
                        // empty eof token goes straight to the marker
                        load_byte.data = MARKER_PREFIX;
                        state_d        = ST_MARKER_CODE;
                    end
                end
            end
            ST_STUFF: begin
                if (slot_free) begin
                    load           = 1'b1;
                    load_byte.data = STUFF_BYTE;
                    state_d        = eoi_pending_q ? ST_MARKER_PREFIX : ST_PASS;
                    eoi_pending_d  = 1'b0;
                end
            end
            ST_MARKER_PREFIX: begin
                if (slot_free) begin
                    load           = 1'b1;
                    load_byte.data = MARKER_PREFIX;
                    state_d        = ST_MARKER_CODE;
                end
            end
            default: begin
                if (slot_free) begin
                    load           = 1'b1;
                    load_byte.data = EOI_CODE;
                    load_byte.eoi  = 1'b1;
                    state_d        = ST_PASS;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q       <= ST_PASS;
            eoi_pending_q <= 1'b0;
            out_valid_q   <= 1'b0;
        end else begin
            state_q       <= state_d;
            eoi_pending_q <= eoi_pending_d;
            if (load) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_q <= load_byte;
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

// ==== rtl/code_decoder.sv ====
// code decoder
// input register stage of the output path. clears code bits above the
// code length and drops empty codes unless they close a frame

`default_nettype none

module code_decoder (
    input  wire logic                  clock,
    input  wire logic                  nreset,
    input  wire jpeg_out_pkg::code_t   code_i,
    input  wire logic                  code_valid_i,
    output logic                       code_ready_o,
    output jpeg_out_pkg::code_t        dec_o,
    output logic                       dec_valid_o,
    input  wire logic                  dec_ready_i
);
    import jpeg_out_pkg::*;

    code_t                   dec_q;
    logic                    dec_valid_q;
    logic                    active_q;
    logic                    take;
    logic                    keep;
    logic [MAX_CODE_LEN-1:0] len_mask;

    // held low through reset and the cycle after it
    assign code_ready_o = active_q && (!dec_valid_q || dec_ready_i);
    assign take         = code_valid_i && code_ready_o;

    // an empty last code still ends the frame
    assign keep = (code_i.len != '0) || code_i.last;

    always_comb begin
        if (code_i.len >= LEN_W'(MAX_CODE_LEN)) begin
            len_mask = {MAX_CODE_LEN{1'b1}};
        end else begin
            len_mask = ~({MAX_CODE_LEN{1'b1}} << code_i.len);
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            active_q    <= 1'b0;
            dec_valid_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
            if (take) begin
                dec_valid_q <= keep;
            end else if (dec_ready_i) begin
                dec_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take && keep) begin
            dec_q.bits <= code_i.bits & len_mask;
            dec_q.len  <= code_i.len;
            dec_q.last <= code_i.last;
        end
    end

    assign dec_o       = dec_q;
    assign dec_valid_o = dec_valid_q;

endmodule

`default_nettype wire

// ==== rtl/jpeg_out_pkg.sv ====
// JPEG bitstream output package
// shared code, token and output byte types for the output stage,
// plus the JPEG marker constants used at the end of a frame

`default_nettype none

package jpeg_out_pkg;

    //////////////////////////////////////////////////////////////////////
    // code format

    // longest variable-length code from the entropy coder
    localparam int MAX_CODE_LEN = 32;
    // length field, holds 0 to 32
    localparam int LEN_W = 6;
    // at most 7 held bits plus one full code
    localparam int ACC_W = 40;

    //////////////////////////////////////////////////////////////////////
    // JPEG bytes

    localparam logic [7:0] STUFF_BYTE    = 8'h00;
    localparam logic [7:0] MARKER_PREFIX = 8'hFF;
    localparam logic [7:0] EOI_CODE      = 8'hD9;

    // right-aligned code; bits above len may be garbage on input
    typedef struct packed {
        logic [MAX_CODE_LEN-1:0] bits;
        logic [LEN_W-1:0]        len;
        logic                    last;
    } code_t;

    // packed byte from the bit packer
    // eof marks the padded final byte, or a data-free token
    typedef struct packed {
        logic [7:0] data;
        logic       eof;
    } byte_tok_t;

    // stuffed output byte, eoi set only on the 0xD9 byte
    typedef struct packed {
        logic [7:0] data;
        logic       eoi;
    } out_byte_t;

endpackage

`default_nettype wire

// ==== rtl/jpeg_out_top.sv ====
// JPEG bitstream output stage
// takes variable-length codes with a length and a frame-end flag and
// produces the stuffed JPEG byte stream, each frame closed by 0xFF 0xD9
// code decode, bit packing and byte stuffing run as three stages

`default_nettype none

module jpeg_out_top (
    input  wire logic                  clock,
    input  wire logic                  nreset,
    input  wire jpeg_out_pkg::code_t   code_i,
    input  wire logic                  code_valid_i,
    output logic                       code_ready_o,
    output jpeg_out_pkg::out_byte_t    out_o,
    output logic                       out_valid_o,
    input  wire logic                  out_ready_i
);
    import jpeg_out_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // stage links

    code_t     dec;
    logic      dec_valid;
    logic      dec_ready;
    byte_tok_t tok;
    logic      tok_valid;
    logic      tok_ready;

    code_decoder u_code_decoder (
        .clock        (clock),
        .nreset       (nreset),
        .code_i       (code_i),
        .code_valid_i (code_valid_i),
        .code_ready_o (code_ready_o),
        .dec_o        (dec),
        .dec_valid_o  (dec_valid),
        .dec_ready_i  (dec_ready)
    );

    bit_packer u_bit_packer (
        .clock       (clock),
        .nreset      (nreset),
        .dec_i       (dec),
        .dec_valid_i (dec_valid),
        .dec_ready_o (dec_ready),
        .tok_o       (tok),
        .tok_valid_o (tok_valid),
        .tok_ready_i (tok_ready)
    );

    byte_stuffer u_byte_stuffer (
        .clock       (clock),
        .nreset      (nreset),
        .tok_i       (tok),
        .tok_valid_i (tok_valid),
        .tok_ready_o (tok_ready),
        .out_o       (out_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the JPEG output stage testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing --top-module tb_jpeg_out -f sources.f -o sim_jpeg_out \
    && ./obj_dir/sim_jpeg_out > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
rtl/jpeg_out_pkg.sv
rtl/code_decoder.sv
rtl/bit_packer.sv
rtl/byte_stuffer.sv
rtl/jpeg_out_top.sv
tests/tb_jpeg_out.sv

// ==== tests/tb_jpeg_out.sv ====
// testbench for the JPEG bitstream output stage
// directed and random frames go in as codes, a reference model builds
// the expected stuffed byte stream, and a monitor compares every byte

`default_nettype none

module tb_jpeg_out;
    timeunit 1ns;
    timeprecision 100ps;
    import jpeg_out_pkg::*;

    typedef code_t     code_q_t[$];
    typedef out_byte_t byte_q_t[$];

    logic        clock;
    logic        nreset;
    code_t       code_i;
    logic        code_valid_i;
    logic        code_ready_o;
    out_byte_t   out_o;
    logic        out_valid_o;
    logic        out_ready_i;

    code_q_t     frame_q;
    code_q_t     stim_q;
    byte_q_t     exp_q;
    int          tag_q[$];
    int          frame_cnt;
    int          byte_idx;
    int          stall_at;
    int          codes_sent;
    int          stall_left;
    int          cycle_cnt;
    int          cycle_limit;
    logic [15:0] gen_lfsr;
    out_byte_t   expected;

    jpeg_out_top DUT (
        .clock        (clock),
        .nreset       (nreset),
        .code_i       (code_i),
        .code_valid_i (code_valid_i),
        .code_ready_o (code_ready_o),
        .out_o        (out_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    // taps x^16 + x^14 + x^13 + x^11
    // new bit enters at the bottom
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int count,
                             output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            state = lfsr_next(state);
            value = {value[30:0], state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // expected bytes of one frame from the low len bits of each code
    // ones pad the last byte and 0x00 follows each 0xFF data byte
    // the frame closes with the end-of-image marker
    function automatic byte_q_t ref_frame(input code_q_t codes);
        bit         stream[$];
        byte_q_t    result;
        out_byte_t  ob;
        logic [7:0] data;
        int         b;
        int         i;
        int         k;
        foreach (codes[c]) begin
            for (b = int'(codes[c].len) - 1; b >= 0; b--) begin
                stream.push_back(codes[c].bits[b]);
            end
        end
        while (stream.size() % 8 != 0) begin
            stream.push_back(1'b1);
        end
        for (i = 0; i < stream.size(); i = i + 8) begin
            data = 8'h00;
            for (k = 0; k < 8; k++) begin
                data = {data[6:0], stream[i + k]};
            end
            ob.data = data;
            ob.eoi  = 1'b0;
            result.push_back(ob);
            if (data == 8'hFF) begin
                ob.data = 8'h00;
                result.push_back(ob);
            end
        end
        ob.data = 8'hFF;
        ob.eoi  = 1'b0;
        result.push_back(ob);
        ob.data = 8'hD9;
        ob.eoi  = 1'b1;
        result.push_back(ob);
        return result;
    endfunction

    task automatic add_code(input logic [31:0] bits, input int len, input bit last);
        code_t c;
        c.bits = bits;
        c.len  = LEN_W'(len);
        c.last = last;
        frame_q.push_back(c);
    endtask

    task automatic end_frame();
        byte_q_t frame_bytes;
        frame_bytes = ref_frame(frame_q);
        foreach (frame_bytes[i]) begin
            exp_q.push_back(frame_bytes[i]);
            tag_q.push_back(frame_cnt);
        end
        foreach (frame_q[i]) begin
            stim_q.push_back(frame_q[i]);
        end
        frame_q.delete();
        frame_cnt++;
    endtask

    // random lengths 0 to 32 with garbage bits above len
    task automatic random_frame(input int n_codes, input bit ones_runs);
        logic [31:0] v;
        logic [31:0] bits;
        int          len;
        int          n;
        for (n = 0; n < n_codes; n++) begin
            draw_bits(gen_lfsr, 6, v);
            len = int'(v % 33);
            draw_bits(gen_lfsr, 32, bits);
            if (ones_runs) begin
                draw_bits(gen_lfsr, 1, v);
                if (v[0]) begin
                    bits = 32'hFFFF_FFFF;
                    len  = 32;
                end
            end
            add_code(bits, len, n == n_codes - 1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // random output ready with one long stall inside frame 1

    initial begin
        logic [15:0] rdy_lfsr;
        logic [31:0] r;
        bit          stall_done;
        out_ready_i = 1'b0;
        rdy_lfsr    = 16'd27845;
        stall_left  = 0;
        stall_done  = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            if (!stall_done && codes_sent > stall_at) begin
                stall_left = 80;
                stall_done = 1'b1;
            end
            if (stall_left > 0) begin
                out_ready_i = 1'b0;
                stall_left  = stall_left - 1;
            end else begin
                draw_bits(rdy_lfsr, 2, r);
                out_ready_i = (r[1:0] != 2'b00);
            end
        end
    end

    // compare each output transfer against the reference stream
    always @(negedge clock) begin
        if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("an output byte arrived after the expected stream had ended");
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                expected = exp_q.pop_front();
                check_value($sformatf("frame %0d byte %0d {data,eoi}", tag_q.pop_front(),
                                      byte_idx), 32'(expected), 32'(out_o));
                byte_idx = expected.eoi ? 0 : byte_idx + 1;
            end
        end
    end

    // by the end of the long stall the input must be blocked
    always @(negedge clock) begin
        if (stall_left == 1) begin
            check_value("long stall code_ready_o", 32'd0, 32'(code_ready_o));
        end
    end

    always @(posedge clock) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the output stream did not complete in %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        logic [31:0] gap;
        logic        ok;
        int          n;
        nreset       = 1'b1;
        code_i       = '0;
        code_valid_i = 1'b0;
        codes_sent   = 0;
        gen_lfsr     = 16'd27845;

        // frame 0 ends on a byte boundary with an empty last code
        add_code(32'hFFFF_FFFF, 32, 1'b0);
        add_code(32'hDEAD_BEE3, 2, 1'b0);
        add_code(32'hDEAD_BEEF, 0, 1'b0);
        add_code(32'h1234_5675, 3, 1'b0);
        add_code(32'hFFFF_FFF8, 3, 1'b0);
        add_code(32'hCAFE_F00D, 0, 1'b1);
        end_frame();
        stall_at = stim_q.size() + 5;
        random_frame(20, 1'b0);
        end_frame();
        random_frame(12, 1'b1);
        end_frame();
        // padded final byte that is itself 0xFF
        add_code(32'h0000_0001, 1, 1'b1);
        end_frame();
        // plain padded final byte
        add_code(32'hFFFF_FFF2, 3, 1'b1);
        end_frame();
        cycle_limit = 10 * exp_q.size() + 200;

        repeat (2) begin
            @(negedge clock);
            check_value("reset out_valid_o", 32'd0, 32'(out_valid_o));
            check_value("reset code_ready_o", 32'd0, 32'(code_ready_o));
        end
        @(posedge clock);
        #1;
        nreset = 1'b0;
        @(negedge clock);
        check_value("after reset out_valid_o", 32'd0, 32'(out_valid_o));
        check_value("after reset code_ready_o", 32'd0, 32'(code_ready_o));
        @(posedge clock);
        #1;

        for (n = 0; n < stim_q.size(); n++) begin
            draw_bits(gen_lfsr, 2, gap);
            if (gap[1:0] == 2'b00) begin
                code_valid_i = 1'b0;
                @(posedge clock);
                #1;
            end
            code_i       = stim_q[n];
            code_valid_i = 1'b1;
            ok           = 1'b0;
            while (!ok) begin
                @(negedge clock);
                ok = code_ready_o;
                @(posedge clock);
            end
            codes_sent = n + 1;
            #1;
        end
        code_valid_i = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
        // quiet period to catch any extra bytes
        repeat (20) @(negedge clock);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
